//--- nes_pkg.sv
package nes_pkg;

    // Bus widths
    typedef logic [15:0] addr_t;
    typedef logic [7:0]  data_t;
    typedef logic [10:0] ram_addr_t;
    typedef logic [13:0] rom_addr_t;

    // Bit 0 is A through bit 7 Right
    typedef logic [7:0]  buttons_t;

    // PPU register select, OAMDMA sits past the eight mirrored registers
    typedef enum logic [3:0] {
        PPUCTRL   = 4'd0,
        PPUMASK   = 4'd1,
        PPUSTATUS = 4'd2,
        OAMADDR   = 4'd3,
        OAMDATA   = 4'd4,
        PPUSCROLL = 4'd5,
        PPUADDR   = 4'd6,
        PPUDATA   = 4'd7,
        OAMDMA    = 4'd8
    } reg_t;

    // Decoded CPU address regions
    typedef enum logic [2:0] {
        REGION_NONE   = 3'd0,
        REGION_RAM    = 3'd1,
        REGION_PPU    = 3'd2,
        REGION_JOYPAD = 3'd3,
        REGION_ROM    = 3'd4
    } region_t;

    // Memory sizes in bytes
    localparam int RAM_DEPTH = 2048;
    localparam int ROM_DEPTH = 16384;

    // Single-address I/O
    localparam addr_t JOYPAD_ADDR = 16'h4016;
    localparam addr_t OAMDMA_ADDR = 16'h4014;

endpackage : nes_pkg

//--- cpu_bus_decode.sv
`timescale 1ns/1ps

module cpu_bus_decode (
    input  nes_pkg::addr_t   addr,
    input  logic             r_en,
    input  nes_pkg::data_t   w_data,
    output nes_pkg::region_t region,
    output logic             ram_wr_en,
    output logic             joy_wr_en,
    output logic             joy_rd_en,
    output nes_pkg::reg_t    reg_sel,
    output logic             reg_en,
    output logic             reg_rw,
    output nes_pkg::data_t   reg_data_wr
);

    import nes_pkg::*;

    // Region from the upper address bits
    always_comb begin
        region = REGION_NONE;
        if (addr[15:13] == 3'b000) begin
            region = REGION_RAM;
        end else if (addr[15:13] == 3'b001) begin
            region = REGION_PPU;
        end else if (addr == OAMDMA_ADDR) begin
            region = REGION_PPU;
        end else if (addr == JOYPAD_ADDR) begin
            region = REGION_JOYPAD;
        end else if (addr[15]) begin
            region = REGION_ROM;
        end
    end

    // Strobes toward the local memories
    assign ram_wr_en = (region == REGION_RAM) && !r_en;
    assign joy_wr_en = (region == REGION_JOYPAD) && !r_en;
    assign joy_rd_en = (region == REGION_JOYPAD) && r_en;

    // PPU port
    always_comb begin
        reg_sel = PPUCTRL;
        reg_en  = 1'b0;
        if (addr[15:13] == 3'b001) begin
            reg_en = 1'b1;
            // Eight registers mirrored every 8 bytes
            case (addr[2:0])
                3'd0: reg_sel = PPUCTRL;
                3'd1: reg_sel = PPUMASK;
                3'd2: reg_sel = PPUSTATUS;
                3'd3: reg_sel = OAMADDR;
                3'd4: reg_sel = OAMDATA;
                3'd5: reg_sel = PPUSCROLL;
                3'd6: reg_sel = PPUADDR;
                default: reg_sel = PPUDATA;
            endcase
        end else if (addr == OAMDMA_ADDR) begin
            reg_en  = 1'b1;
            reg_sel = OAMDMA;
        end
    end

    // High for a write
    assign reg_rw      = ~r_en;
    assign reg_data_wr = w_data;

endmodule : cpu_bus_decode

//--- work_ram.sv
`timescale 1ns/1ps

module work_ram (
    input  logic               clock,
    input  logic               clock_en,
    input  logic               reset_n,
    input  nes_pkg::ram_addr_t addr,
    input  logic               wr_en,
    input  nes_pkg::data_t     w_data,
    output nes_pkg::data_t     rd_data
);

    import nes_pkg::*;

    data_t mem [RAM_DEPTH];

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < RAM_DEPTH; i++) begin
                mem[i] <= '0;
            end
            rd_data <= '0;
        end else if (clock_en) begin
            if (wr_en) begin
                mem[addr] <= w_data;
            end
            // Old contents on a write cycle, never returned
            rd_data <= mem[addr];
        end
    end

endmodule : work_ram

//--- prg_rom.sv
`timescale 1ns/1ps

module prg_rom (
    input  logic               clock,
    input  logic               clock_en,
    input  nes_pkg::rom_addr_t addr,
    output nes_pkg::data_t     rd_data
);

    import nes_pkg::*;

    data_t mem [ROM_DEPTH];

    // Zero fill, then the image covers the start of the bank
    initial begin
        for (int i = 0; i < ROM_DEPTH; i++) begin
            mem[i] = '0;
        end
        $readmemh("prg_rom.hex", mem);
    end

    always_ff @(posedge clock) begin
        if (clock_en) begin
            rd_data <= mem[addr];
        end
    end

endmodule : prg_rom

//--- joypad_port.sv
`timescale 1ns/1ps

module joypad_port (
    input  logic              clock,
    input  logic              clock_en,
    input  logic              reset_n,
    input  logic              wr_en,
    input  logic              w_bit,
    input  logic              rd_en,
    input  nes_pkg::buttons_t buttons,
    output nes_pkg::data_t    rd_data
);

    import nes_pkg::*;

    logic     strobe;
    buttons_t shift_reg;
    logic     rd_bit;

    // Strobe latch from bit 0 of the write
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            strobe <= 1'b0;
        end else if (clock_en && wr_en) begin
            strobe <= w_bit;
        end
    end

    // Parallel load while strobed, else shift out A first
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            shift_reg <= '0;
        end else if (clock_en) begin
            if (strobe) begin
                shift_reg <= buttons;
            end else if (rd_en) begin
                // Ones fill in behind, so reads past Right give 1
                shift_reg <= {1'b1, shift_reg[7:1]};
            end
        end
    end

    // Serial bit captured on each read
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            rd_bit <= 1'b0;
        end else if (clock_en && rd_en) begin
            rd_bit <= shift_reg[0];
        end
    end

    assign rd_data = {7'b0, rd_bit};

endmodule : joypad_port

//--- read_return.sv
`timescale 1ns/1ps

module read_return (
    input  logic             clock,
    input  logic             clock_en,
    input  logic             reset_n,
    input  nes_pkg::region_t region,
    input  logic             r_en,
    input  nes_pkg::data_t   ram_data,
    input  nes_pkg::data_t   rom_data,
    input  nes_pkg::data_t   joy_data,
    input  nes_pkg::data_t   reg_data_rd,
    output nes_pkg::data_t   r_data
);

    import nes_pkg::*;

    region_t region_q;

    // Region of the read in flight, writes return nothing
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            region_q <= REGION_NONE;
        end else if (clock_en) begin
            region_q <= r_en ? region : REGION_NONE;
        end
    end

    // PPU data comes straight from the port in the return cycle
    always_comb begin
        case (region_q)
            REGION_RAM:    r_data = ram_data;
            REGION_ROM:    r_data = rom_data;
            REGION_JOYPAD: r_data = joy_data;
            REGION_PPU:    r_data = reg_data_rd;
            default:       r_data = '0;
        endcase
    end

endmodule : read_return

//--- nes_cpu_bus.sv
`timescale 1ns/1ps

module nes_cpu_bus (
    input  logic              clock,
    input  logic              clock_en,
    input  logic              reset_n,
    input  nes_pkg::addr_t    addr,
    input  logic              r_en,
    input  nes_pkg::data_t    w_data,
    input  nes_pkg::buttons_t buttons,
    output nes_pkg::data_t    r_data,
    output nes_pkg::reg_t     reg_sel,
    output logic              reg_en,
    output logic              reg_rw,
    output nes_pkg::data_t    reg_data_wr,
    input  nes_pkg::data_t    reg_data_rd
);

    import nes_pkg::*;

    region_t region;
    logic    ram_wr_en;
    logic    joy_wr_en;
    logic    joy_rd_en;
    data_t   ram_data;
    data_t   rom_data;
    data_t   joy_data;

    cpu_bus_decode i_cpu_bus_decode (
        .addr        (addr),
        .r_en        (r_en),
        .w_data      (w_data),
        .region      (region),
        .ram_wr_en   (ram_wr_en),
        .joy_wr_en   (joy_wr_en),
        .joy_rd_en   (joy_rd_en),
        .reg_sel     (reg_sel),
        .reg_en      (reg_en),
        .reg_rw      (reg_rw),
        .reg_data_wr (reg_data_wr)
    );

    // 2 KB mirrored four times below $2000
    work_ram i_work_ram (
        .clock    (clock),
        .clock_en (clock_en),
        .reset_n  (reset_n),
        .addr     (addr[10:0]),
        .wr_en    (ram_wr_en),
        .w_data   (w_data),
        .rd_data  (ram_data)
    );

    // 16 KB mirrored twice above $8000
    prg_rom i_prg_rom (
        .clock    (clock),
        .clock_en (clock_en),
        .addr     (addr[13:0]),
        .rd_data  (rom_data)
    );

    joypad_port i_joypad_port (
        .clock    (clock),
        .clock_en (clock_en),
        .reset_n  (reset_n),
        .wr_en    (joy_wr_en),
        .w_bit    (w_data[0]),
        .rd_en    (joy_rd_en),
        .buttons  (buttons),
        .rd_data  (joy_data)
    );

    read_return i_read_return (
        .clock       (clock),
        .clock_en    (clock_en),
        .reset_n     (reset_n),
        .region      (region),
        .r_en        (r_en),
        .ram_data    (ram_data),
        .rom_data    (rom_data),
        .joy_data    (joy_data),
        .reg_data_rd (reg_data_rd),
        .r_data      (r_data)
    );

endmodule : nes_cpu_bus

//--- tb_nes_cpu_bus.sv
`timescale 1ns/1ps

module tb_nes_cpu_bus;

    import nes_pkg::*;

    localparam int CLK_PERIOD     = 100;
    localparam int MAX_ROWS       = 256;
    localparam int CYCLES_PER_ROW = 8;

    typedef struct packed {
        addr_t    addr;
        logic     rd;
        data_t    w_data;
        buttons_t buttons;
        data_t    ppu_data;
        data_t    exp_data;
    } row_t;

    logic     clock;
    logic     clock_en;
    logic     reset_n;
    addr_t    addr;
    logic     r_en;
    data_t    w_data;
    buttons_t buttons;
    data_t    r_data;
    reg_t     reg_sel;
    logic     reg_en;
    logic     reg_rw;
    data_t    reg_data_wr;
    data_t    reg_data_rd;

    row_t        table_rows [MAX_ROWS];
    int          n_rows;
    bit          table_ready;
    logic [31:0] lfsr;

    // Reference model state
    data_t    ref_ram [RAM_DEPTH];
    data_t    ref_rom [ROM_DEPTH];
    logic     ref_strobe;
    buttons_t ref_shift;

    nes_cpu_bus i_nes_cpu_bus (
        .clock       (clock),
        .clock_en    (clock_en),
        .reset_n     (reset_n),
        .addr        (addr),
        .r_en        (r_en),
        .w_data      (w_data),
        .buttons     (buttons),
        .r_data      (r_data),
        .reg_sel     (reg_sel),
        .reg_en      (reg_en),
        .reg_rw      (reg_rw),
        .reg_data_wr (reg_data_wr),
        .reg_data_rd (reg_data_rd)
    );

    initial clock = 1'b0;
    always #(CLK_PERIOD / 2) clock = ~clock;

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        logic        out;
        v = '0;
        for (int i = 0; i < n; i++) begin
            out  = lfsr[0];
            lfsr = lfsr >> 1;
            if (out) lfsr = lfsr ^ 32'h8020_0003;
            v = {v[30:0], out};
        end
        return v;
    endfunction

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_data(input int row, input data_t got, input data_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Error at %0t: r_data before row %0d is %02h, expected %02h",
                                $time, row, got, exp));
        end
    endtask

    task automatic check_port(input int row, input reg_t sel, input logic en, input logic rw,
                              input data_t wr, input reg_t exp_sel, input logic exp_en,
                              input logic exp_rw, input data_t exp_wr);
        if (en !== exp_en || rw !== exp_rw || wr !== exp_wr || (exp_en && sel !== exp_sel)) begin
            abort_run($sformatf({"Error at %0t: PPU port in row %0d is sel %0d en %b rw %b ",
                                 "data %02h, expected sel %0d en %b rw %b data %02h"},
                                $time, row, sel, en, rw, wr, exp_sel, exp_en, exp_rw, exp_wr));
        end
    endtask

    // One row per enabled bus cycle with the model stepped alongside
    task automatic add_row(input addr_t a, input logic rd, input data_t wd,
                           input buttons_t btn, input data_t ppu);
        row_t  r;
        data_t val;
        val = '0;
        if (rd) begin
            if (a < 16'h2000) val = ref_ram[a[10:0]];
            else if (a < 16'h4000 || a == OAMDMA_ADDR) val = ppu;
            else if (a == JOYPAD_ADDR) val = {7'b0, ref_shift[0]};
            else if (a >= 16'h8000) val = ref_rom[a[13:0]];
        end
        if (ref_strobe) ref_shift = btn;
        else if (rd && a == JOYPAD_ADDR) ref_shift = {1'b1, ref_shift[7:1]};
        if (!rd && a == JOYPAD_ADDR) ref_strobe = wd[0];
        if (!rd && a < 16'h2000) ref_ram[a[10:0]] = wd;
        r.addr     = a;
        r.rd       = rd;
        r.w_data   = wd;
        r.buttons  = btn;
        r.ppu_data = ppu;
        r.exp_data = val;
        table_rows[n_rows] = r;
        n_rows++;
    endtask

    task automatic build_table();
        addr_t    ram_addrs [12];
        addr_t    ppu_addrs [11];
        addr_t    a;
        buttons_t btn;
        n_rows = 0;
        btn    = '0;
        for (int i = 0; i < RAM_DEPTH; i++) ref_ram[i] = '0;
        for (int i = 0; i < ROM_DEPTH; i++) ref_rom[i] = '0;
        $readmemh("prg_rom.hex", ref_rom);
        ref_strobe = 1'b0;
        ref_shift  = '0;
        // RAM read back through a mirror picked by bits 12:11
        for (int i = 0; i < 12; i++) begin
            ram_addrs[i] = {3'b000, 13'(random_bits(13))};
            add_row(ram_addrs[i], 1'b0, 8'(random_bits(8)), btn, '0);
        end
        for (int i = 0; i < 12; i++) begin
            a = ram_addrs[i];
            a[12:11] = a[12:11] ^ 2'(i % 4);
            add_row(a, 1'b1, 8'(random_bits(8)), btn, '0);
        end
        // ROM in both 16 KB mirrors and writes that must not stick
        for (int i = 0; i < 32; i++) begin
            add_row(16'h8000 + 16'(i), 1'b1, '0, btn, '0);
            add_row(16'hC000 + 16'(i), 1'b1, '0, btn, '0);
        end
        add_row(16'h8005, 1'b0, 8'h5A, btn, '0);
        add_row(16'hC00A, 1'b0, 8'hA5, btn, '0);
        add_row(16'h8005, 1'b1, '0, btn, '0);
        add_row(16'h800A, 1'b1, '0, btn, '0);
        ppu_addrs = '{16'h2000, 16'h2001, 16'h2002, 16'h2003, 16'h2004, 16'h2005,
                      16'h2006, 16'h2007, 16'h3FF9, 16'h2A0E, 16'h4014};
        for (int i = 0; i < 11; i++) begin
            add_row(ppu_addrs[i], 1'b0, 8'(random_bits(8)), btn, 8'(random_bits(8)));
            add_row(ppu_addrs[i], 1'b1, 8'(random_bits(8)), btn, 8'(random_bits(8)));
        end
        // Strobe high then low before eight buttons and one trailing 1
        for (int round = 0; round < 2; round++) begin
            btn = 8'(random_bits(8));
            add_row(JOYPAD_ADDR, 1'b0, 8'h01, btn, '0);
            add_row(JOYPAD_ADDR, 1'b0, 8'h00, btn, '0);
            for (int i = 0; i < 9; i++) add_row(JOYPAD_ADDR, 1'b1, 8'hFF, btn, '0);
        end
        add_row(16'h5000, 1'b1, '0, btn, 8'hFF);
        add_row(16'h4017, 1'b1, '0, btn, 8'hFF);
        add_row(16'h6000, 1'b0, 8'h77, btn, 8'hFF);
        add_row(16'h6000, 1'b1, '0, btn, 8'hFF);
        add_row(16'h4015, 1'b1, '0, btn, 8'hFF);
        add_row(16'h7FFF, 1'b1, '0, btn, 8'hFF);
        // RAM once more after many held cycles
        for (int i = 0; i < 12; i++) add_row(ram_addrs[i], 1'b1, '0, btn, '0);
    endtask

    initial begin
        wait (table_ready);
        #((n_rows * CYCLES_PER_ROW + 10) * CLK_PERIOD);
        abort_run($sformatf("Timeout: the %0d table rows did not finish in time", n_rows));
    end

    initial begin
        row_t  r;
        logic  ce;
        logic  exp_en;
        reg_t  exp_sel;
        data_t exp_data;
        $timeformat(-9, 0, " ns", 0);
        clock_en    = 1'b0;
        reset_n     = 1'b0;
        addr        = '0;
        r_en        = 1'b1;
        w_data      = '0;
        buttons     = '0;
        reg_data_rd = '0;
        lfsr        = 32'he522_5244;
        build_table();
        table_ready = 1'b1;
        repeat (4) @(negedge clock);
        reset_n  = 1'b1;
        exp_data = '0;
        for (int k = 0; k < n_rows; k++) begin
            r  = table_rows[k];
            ce = 1'b0;
            while (!ce) begin
                @(negedge clock);
                check_data(k, r_data, exp_data);
                ce       = (random_bits(2) != 32'd0);
                clock_en = ce;
                addr     = r.addr;
                if (ce) begin
                    r_en        = r.rd;
                    w_data      = r.w_data;
                    buttons     = r.buttons;
                    reg_data_rd = r.ppu_data;
                end else begin
                    // Stray access and button change ignored by a held cycle
                    r_en    = (random_bits(1) != 32'd0);
                    w_data  = ~r.w_data;
                    buttons = ~r.buttons;
                end
            end
            @(posedge clock);
            exp_en  = (r.addr >= 16'h2000 && r.addr <= 16'h3FFF) || r.addr == OAMDMA_ADDR;
            exp_sel = (r.addr == OAMDMA_ADDR) ? OAMDMA : reg_t'({1'b0, r.addr[2:0]});
            check_port(k, reg_sel, reg_en, reg_rw, reg_data_wr, exp_sel, exp_en, !r.rd, r.w_data);
            exp_data = r.exp_data;
        end
        @(negedge clock);
        check_data(n_rows, r_data, exp_data);
        $display("RESULT: PASS");
        $finish;
    end

endmodule : tb_nes_cpu_bus

//--- prg_rom.hex
// One hex byte per line, program ROM from offset 0
78
D8
A9
10
8D
00
20
A2
FF
9A
AD
02
20
10
FB
A9
01
8D
16
40
A9
00
8D
16
40
AD
16
40
4C
1A
80
EA

//--- nes_cpu_bus.f
nes_pkg.sv
cpu_bus_decode.sv
work_ram.sv
prg_rom.sv
joypad_port.sv
read_return.sv
nes_cpu_bus.sv
tb_nes_cpu_bus.sv

//--- Bender.yml
package:
  name: nes_cpu_bus

sources:
  - nes_pkg.sv
  - cpu_bus_decode.sv
  - work_ram.sv
  - prg_rom.sv
  - joypad_port.sv
  - read_return.sv
  - nes_cpu_bus.sv
  - target: test
    files:
      - tb_nes_cpu_bus.sv
